/* tb.f */
mb_machine_pkg.sv
mb_micro_pkg.sv
mb_sequencer.sv
mb_mode_flags.sv
mb_modifier_mem.sv
mb_bus_regs.sv
mb_cpu_ctl.sv
tb_mb_cpu_ctl.sv

/* Makefile */
# Verilator simulation of the Micro-BESM control core
VERILATOR ?= verilator
TOP       ?= tb_mb_cpu_ctl
# Decimal form of 32'h0c39_1f99
SEED      ?= 205070233
LOG       ?= sim.log
OBJ_DIR   ?= obj_dir
FILELIST  ?= tb.f

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) --binary --timing --assert --top-module $(TOP) -GSEED=$(SEED) \
		-f $(FILELIST) --Mdir $(OBJ_DIR) -o V$(TOP)

run: compile
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "TEST FAILED" $(LOG); then echo "Simulation failed"; exit 1; fi
	@grep -q "TEST PASSED" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* tb_mb_cpu_ctl.sv */
`default_nettype none
`timescale 1ns/1ps

module tb_mb_cpu_ctl #(
    parameter int SEED = 32'h0c39_1f99
);

    localparam int RESET_CYCLES = 3;
    localparam int NUM_CYCLES   = 3000;
    localparam int TIMEOUT      = NUM_CYCLES + 200;              // Random run plus margin
    localparam int DEPTH        = mb_machine_pkg::STACK_DEPTH_DEF;

    logic                      clk = 1'b0;
    logic                      reset;
    mb_micro_pkg::uinstr_t     uinstr;
    mb_machine_pkg::word_t     y;
    mb_machine_pkg::uaddr_t    uaddr;
    mb_machine_pkg::word_t     d;
    integer                    seed;
    int                        cycles = 0;

    // ----------------------------------------------
    // Reference model state
    mb_machine_pkg::uaddr_t    m_upc;
    mb_machine_pkg::uaddr_t    m_stack [DEPTH];
    int                        m_sp;                             // Entries in use
    mb_machine_pkg::mode_reg_t m_rr;
    logic                      m_tr0;
    logic                      m_tr1;
    logic                      m_tkk;
    logic                      m_emul;
    mb_machine_pkg::modgn_t    m_modgn;
    mb_machine_pkg::procn_t    m_procn;
    mb_machine_pkg::word_t     m_ureg;
    mb_machine_pkg::word_t     m_mem [1024];
    bit                        m_written [1024];                 // Entries with known data

    mb_cpu_ctl mb_cpu_ctl_i (
        .clk, .reset, .i_uinstr(uinstr), .i_y(y), .o_uaddr(uaddr), .o_d(d)
    );

    always #10 clk = ~clk;                                       // 20 ns period

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT) begin
            $display("Timeout: the run did not finish within %0d cycles", TIMEOUT);
            $display("TEST FAILED");
            $fatal(1, "Simulation stopped by the cycle limit");
        end
    end

    task automatic compare_value(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
        if (got !== exp) begin
            $display("FAILED %s: got %h, expected %h", name, got, exp);
            $display("TEST FAILED");
            $fatal(1, "Mismatch on %s", name);
        end
    endtask

    task automatic reset_model();
        m_upc   = '0;
        m_sp    = 0;
        m_rr    = '0;
        m_tr0   = 1'b0;
        m_tr1   = 1'b0;
        m_tkk   = 1'b0;
        m_emul  = 1'b0;
        m_modgn = '0;
        m_procn = '0;
        m_ureg  = '0;
        foreach (m_written[i]) m_written[i] = 1'b0;           // Memory itself has no reset
    endtask

    // Condition multiplexer of the model
    function automatic logic cond_value(input logic [4:0] code);
        case (code)
            5'd1:    return m_rr.normb;
            5'd2:    return m_rr.rndb;
            5'd3:    return m_rr.ovrib;
            5'd4:    return m_rr.bnb;
            5'd5:    return m_rr.ovrftb;
            5'd6:    return m_rr.drg;
            5'd7:    return m_emul;
            5'd8:    return m_rr.rcb;
            5'd9:    return m_rr.cb;
            5'd10:   return m_rr.cemlrg;
            5'd12:   return m_tr1;
            5'd13:   return m_rr.intstp;
            5'd15:   return m_tkk;
            5'd22:   return m_tr0;
            default: return 1'b1;                                // Code 0, dropped sources
        endcase
    endfunction

    // ----------------------------------------------
    // Random microinstruction, biased toward kept codes
    task automatic drive_random(input int cyc);
        logic [31:0] r1;
        logic [31:0] r2;
        logic [31:0] r3;
        r1 = $random(seed);
        r2 = $random(seed);
        r3 = $random(seed);
        case (r1[2:0])
            3'd0:    uinstr.sqi = mb_micro_pkg::SQ_CJS;
            3'd1:    uinstr.sqi = mb_micro_pkg::SQ_CRTN;
            3'd2:    uinstr.sqi = mb_micro_pkg::SQ_CJP;
            3'd3:    uinstr.sqi = mb_micro_pkg::SQ_JMAP;
            3'd4:    uinstr.sqi = (r1[5:3] == 3'd0) ? mb_micro_pkg::SQ_JZ
                                                    : mb_micro_pkg::seq_op_e'(r1[9:6]);
            default: uinstr.sqi = mb_micro_pkg::SQ_CONT;
        endcase
        uinstr.a     = (r1[11:10] == 2'd0) ? {11'h7ff, r1[12]} : r1[23:12];  // Near wrap
        uinstr.map   = r1[25:24];
        uinstr.sci   = r1[26];
        uinstr.ici   = r1[27];
        uinstr.icc   = r1[28];
        uinstr.ise   = (r1[31:29] == 3'd0);                      // Rare
        uinstr.iomp  = r2[0];
        uinstr.ffcnt = r2[5:1];
        uinstr.cond  = r2[10:6];
        uinstr.csm   = r2[11];
        uinstr.wem   = r2[12];
        uinstr.mod   = r2[13];
        uinstr.mnsa  = r2[15:14];
        uinstr.modnm = r2[20:16];
        uinstr.dsrc  = mb_micro_pkg::dsrc_e'(r2[24] ? r2[24:21] : {2'b00, r2[22:21]});
        case (r2[27:25])
            3'd1:    uinstr.ydst = mb_micro_pkg::YD_MODGN;
            3'd2:    uinstr.ydst = mb_micro_pkg::YD_PROCN;
            3'd3:    uinstr.ydst = mb_micro_pkg::YD_RR;
            3'd4:    uinstr.ydst = mb_micro_pkg::YD_UREG;
            3'd5:    uinstr.ydst = mb_micro_pkg::ydst_e'(r3[3:0]);
            default: uinstr.ydst = mb_micro_pkg::YD_NONE;
        endcase
        uinstr.ddev  = r2[30:28];
        uinstr.spare = 2'b00;
        if (cyc < 3)
            uinstr.dsrc = mb_micro_pkg::dsrc_e'(4'(cyc + 1));    // Registers right after reset
        y = r3;
        if (r3[31])
            y[9:7] = 3'd0;                                       // Few groups, more reuse
    endtask

    // ----------------------------------------------
    // Expected outputs, compare, then advance the model
    task automatic check_and_step();
        logic                    ncc;
        logic                    pass;
        logic                    cin;
        logic                    old_tkk;
        mb_machine_pkg::uaddr_t  dval;
        mb_machine_pkg::uaddr_t  addr;
        mb_machine_pkg::modnum_t mn;
        logic [9:0]              idx;
        logic                    prot;
        mb_machine_pkg::word_t   d_exp;
        logic                    d_known;
        ncc  = uinstr.icc ? cond_value(uinstr.cond) : ~cond_value(uinstr.cond);
        pass = ~ncc;                                             // Test passes on low
        cin  = (uinstr.sci ? ncc : 1'b1) ^ uinstr.ici;
        dval = (uinstr.map == 2'd3) ? y[11:0] : uinstr.a;
        addr = m_upc;
        case (uinstr.sqi)
            mb_micro_pkg::SQ_JZ:   addr = '0;
            mb_micro_pkg::SQ_CJS:  if (pass) addr = dval;
            mb_micro_pkg::SQ_JMAP: addr = dval;
            mb_micro_pkg::SQ_CJP:  if (pass) addr = dval;
            mb_micro_pkg::SQ_CRTN: if (pass) addr = (m_sp == 0) ? '0 : m_stack[m_sp - 1];
            default: ;
        endcase
        case (uinstr.mnsa)
            2'd0:    mn = m_ureg[4:0];
            2'd3:    mn = ~uinstr.modnm;
            default: mn = 5'd0;
        endcase
        idx     = {m_modgn, mn};
        prot    = mn[4] && uinstr.mnsa != 2'd3 && !uinstr.mod;   // Privileged half
        d_known = 1'b1;
        d_exp   = '0;
        case (uinstr.dsrc)
            mb_micro_pkg::DS_MODGN: d_exp = {21'd0, 1'b1, m_modgn, 5'd0};
            mb_micro_pkg::DS_PROCN: d_exp = {24'd0, m_procn};
            mb_micro_pkg::DS_RR:    d_exp = m_rr;
            default: if (uinstr.csm && !uinstr.wem && !prot) begin
                d_exp   = m_mem[idx];
                d_known = m_written[idx];                        // Skip unwritten entries
            end
        endcase
        compare_value("o_uaddr", {20'd0, uaddr}, {20'd0, addr});
        if (d_known)
            compare_value("o_d", d, d_exp);

        case (uinstr.sqi)                                        // Stack before counter
            mb_micro_pkg::SQ_JZ:   m_sp = 0;
            mb_micro_pkg::SQ_CJS:  if (pass) begin
                if (m_sp == DEPTH) begin
                    m_stack[DEPTH - 1] = m_upc;                  // Full stack, top replaced
                end else begin
                    m_stack[m_sp] = m_upc;
                    m_sp++;
                end
            end
            mb_micro_pkg::SQ_CRTN: if (pass && m_sp > 0) m_sp--;
            default: ;
        endcase
        m_upc = addr + {11'd0, cin};
        if (uinstr.csm && uinstr.wem && !prot && !(mn == 5'd0 && uinstr.mnsa != 2'd3)) begin
            m_mem[idx]     = y;
            m_written[idx] = 1'b1;
        end
        old_tkk = m_tkk;
        if (uinstr.ydst == mb_micro_pkg::YD_RR)
            m_rr = mb_machine_pkg::mode_reg_t'(y);
        if (!uinstr.iomp) begin
            case (uinstr.ffcnt)
                mb_micro_pkg::FF_LOGGRP: m_rr.grp     = 3'b001;
                mb_micro_pkg::FF_MULGRP: m_rr.grp     = 3'b010;
                mb_micro_pkg::FF_ADDGRP: m_rr.grp     = 3'b100;
                mb_micro_pkg::FF_SETC:   m_rr.cb      = 1'b1;
                mb_micro_pkg::FF_CLRRCB: m_rr.rcb     = 1'b0;
                mb_micro_pkg::FF_SETRCB: m_rr.rcb     = 1'b1;
                mb_micro_pkg::FF_CLRJMP: m_rr.jump    = 1'b0;
                mb_micro_pkg::FF_SETJMP: m_rr.jump    = 1'b1;
                mb_micro_pkg::FF_SETEI:  m_rr.no_intr = 1'b0;
                mb_micro_pkg::FF_CLREI:  m_rr.no_intr = 1'b1;
                mb_micro_pkg::FF_CLRTR0: m_tr0        = 1'b0;
                mb_micro_pkg::FF_SETTR0: m_tr0        = 1'b1;
                mb_micro_pkg::FF_CLRTR1: m_tr1        = 1'b0;
                mb_micro_pkg::FF_SETTR1: m_tr1        = 1'b1;
                mb_micro_pkg::FF_CLRTKK: m_tkk        = 1'b0;
                mb_micro_pkg::FF_SETTKK: m_tkk        = 1'b1;
                mb_micro_pkg::FF_SETNR:  m_emul       = 1'b0;
                mb_micro_pkg::FF_SETER:  m_emul       = 1'b1;
                mb_micro_pkg::FF_CHTKK:  m_tkk        = ~old_tkk;
                default: ;
            endcase
        end
        if (uinstr.ddev == 3'd3)
            m_rr.cb = 1'b0;                                      // Clear wins over SETC
        if (uinstr.ise)
            m_rr.rcb = old_tkk;                                  // tkk before this edge
        case (uinstr.ydst)
            mb_micro_pkg::YD_MODGN: m_modgn = y[9:5];
            mb_micro_pkg::YD_PROCN: m_procn = y[7:0];
            mb_micro_pkg::YD_UREG:  m_ureg  = y;
            default: ;
        endcase
    endtask

    initial begin
        seed   = SEED;
        reset  = 1'b1;
        uinstr = '0;
        y      = '0;
        reset_model();
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        for (int cyc = 0; cyc < NUM_CYCLES; cyc++) begin
            drive_random(cyc);                                   // On the falling edge
            #5;                                                  // Settled, before rising edge
            check_and_step();
            @(negedge clk);
        end
        $display("TEST PASSED");
        $finish;
    end

endmodule

`default_nettype wire

/* mb_cpu_ctl.sv */
`default_nettype none
`timescale 1ns/1ps

module mb_cpu_ctl #(
    parameter int STACK_DEPTH = mb_machine_pkg::STACK_DEPTH_DEF
) (
    input  wire                           clk,
    input  wire                           reset,
    input  wire  mb_micro_pkg::uinstr_t   i_uinstr,  // Microinstruction in place of ROM
    input  wire  mb_machine_pkg::word_t   i_y,       // Y bus from ALU side
    output mb_machine_pkg::uaddr_t        o_uaddr,   // Next microaddress
    output mb_machine_pkg::word_t         o_d        // D bus
);

    mb_machine_pkg::mode_reg_t rr;                   // Mode register
    logic                      ncc;                  // Condition, active low
    mb_machine_pkg::word_t     mr_read;              // Modifier read data
    mb_machine_pkg::modgn_t    modgn;                // Modifier group
    mb_machine_pkg::word_t     ureg;                 // Effective address

    mb_sequencer #(.STACK_DEPTH(STACK_DEPTH)) mb_sequencer_i (
        .clk, .reset, .i_uinstr, .i_y, .i_ncc(ncc), .o_uaddr
    );

    mb_mode_flags mb_mode_flags_i (
        .clk, .reset, .i_uinstr, .i_y, .o_rr(rr), .o_ncc(ncc)
    );

    mb_modifier_mem mb_modifier_mem_i (
        .clk, .i_uinstr, .i_y, .i_modgn(modgn), .i_ureg(ureg), .o_mr_read(mr_read)
    );

    mb_bus_regs mb_bus_regs_i (
        .clk, .reset, .i_uinstr, .i_y, .i_rr(rr), .i_mr_read(mr_read),
        .o_modgn(modgn), .o_ureg(ureg), .o_d
    );

endmodule

`default_nettype wire

/* mb_bus_regs.sv */
`default_nettype none
`timescale 1ns/1ps

module mb_bus_regs (
    input  wire                              clk,
    input  wire                              reset,
    input  wire  mb_micro_pkg::uinstr_t      i_uinstr,   // Current microinstruction
    input  wire  mb_machine_pkg::word_t      i_y,        // Y bus
    input  wire  mb_machine_pkg::mode_reg_t  i_rr,       // Mode register
    input  wire  mb_machine_pkg::word_t      i_mr_read,  // Modifier read data
    output mb_machine_pkg::modgn_t           o_modgn,    // Group number register
    output mb_machine_pkg::word_t            o_ureg,     // Effective address register
    output mb_machine_pkg::word_t            o_d         // D bus
);

    mb_machine_pkg::procn_t procn;                        // Process number register

    // --------------------------------------------------
    // Y bus destinations
    always_ff @(posedge clk) begin
        if (reset) begin
            o_modgn <= '0;
            procn   <= '0;
            o_ureg  <= '0;
        end else begin
            case (i_uinstr.ydst)
                mb_micro_pkg::YD_MODGN: o_modgn <= i_y[9:5];
                mb_micro_pkg::YD_PROCN: procn   <= i_y[7:0];
                mb_micro_pkg::YD_UREG:  o_ureg  <= i_y;   // Full word
                default: ;
            endcase
        end
    end

    // --------------------------------------------------
    // D bus sources
    always_comb begin
        case (i_uinstr.dsrc)
            mb_micro_pkg::DS_MODGN: o_d = {21'd0, 1'b1, o_modgn, 5'd0};  // Marker bit 10
            mb_micro_pkg::DS_PROCN: o_d = {24'd0, procn};
            mb_micro_pkg::DS_RR:    o_d = i_rr;
            default: o_d = (i_uinstr.csm && !i_uinstr.wem) ? i_mr_read : '0;
        endcase
    end

endmodule

`default_nettype wire

/* mb_modifier_mem.sv */
`default_nettype none
`timescale 1ns/1ps

module mb_modifier_mem (
    input  wire                           clk,
    input  wire  mb_micro_pkg::uinstr_t   i_uinstr,   // Current microinstruction
    input  wire  mb_machine_pkg::word_t   i_y,        // Write data
    input  wire  mb_machine_pkg::modgn_t  i_modgn,    // Group number
    input  wire  mb_machine_pkg::word_t   i_ureg,     // Effective address register
    output mb_machine_pkg::word_t         o_mr_read   // Read data
);

    mb_machine_pkg::word_t   mem [1024];              // Modifier registers
    mb_machine_pkg::modnum_t mn;                      // Modifier number
    logic [9:0]              idx;                     // Group and number
    logic                    from_ucode;              // Number from MODNM field
    logic                    rd_prot;                 // Privileged entry without MOD
    logic                    mem_we;

    // --------------------------------------------------
    // Number source and protection
    assign from_ucode = (i_uinstr.mnsa == 2'd3);

    always_comb begin
        case (i_uinstr.mnsa)
            2'd0:    mn = i_ureg[4:0];               // From UREG
            2'd3:    mn = ~i_uinstr.modnm;           // Inverted microcode field
            default: mn = '0;
        endcase
    end

    assign idx     = {i_modgn, mn};
    assign rd_prot = mn[4] && !from_ucode && !i_uinstr.mod;  // M16..M31 need MOD

    assign mem_we  = i_uinstr.csm && i_uinstr.wem && !rd_prot
                     && !(mn == '0 && !from_ucode);  // M0 locked for UREG

    assign o_mr_read = rd_prot ? '0 : mem[idx];

    always_ff @(posedge clk) begin
        if (mem_we)
            mem[idx] <= i_y;
    end

    // Protected entry keeps its contents across the edge
    no_prot_write: assert property (@(posedge clk)
        (rd_prot || (!from_ucode && mn == '0))
            |=> mem[$past(idx)] === $past(mem[idx]));

endmodule

`default_nettype wire

/* mb_mode_flags.sv */
`default_nettype none
`timescale 1ns/1ps

module mb_mode_flags (
    input  wire                           clk,
    input  wire                           reset,
    input  wire  mb_micro_pkg::uinstr_t   i_uinstr,  // Current microinstruction
    input  wire  mb_machine_pkg::word_t   i_y,       // Y bus
    output mb_machine_pkg::mode_reg_t     o_rr,      // Mode register
    output logic                          o_ncc      // Condition code, active low
);

    logic tr0;                                       // Microprogram flag 0
    logic tr1;                                       // Microprogram flag 1
    logic tkk;                                       // Standardizer right command
    logic emul_mode;                                 // Emulation mode
    logic cond_bit;                                  // Selected condition

    // --------------------------------------------------
    // RR load and flag decoder
    always_ff @(posedge clk) begin
        if (reset) begin
            o_rr      <= '0;
            tr0       <= 1'b0;
            tr1       <= 1'b0;
            tkk       <= 1'b0;
            emul_mode <= 1'b0;
        end else begin
            if (i_uinstr.ydst == mb_micro_pkg::YD_RR)
                o_rr <= mb_machine_pkg::mode_reg_t'(i_y);  // Lowest priority
            if (!i_uinstr.iomp) begin
                case (i_uinstr.ffcnt)
                    mb_micro_pkg::FF_LOGGRP: o_rr.grp     <= 3'b001;  // Logic group
                    mb_micro_pkg::FF_MULGRP: o_rr.grp     <= 3'b010;  // Multiply group
                    mb_micro_pkg::FF_ADDGRP: o_rr.grp     <= 3'b100;  // Add group
                    mb_micro_pkg::FF_SETC:   o_rr.cb      <= 1'b1;
                    mb_micro_pkg::FF_CLRRCB: o_rr.rcb     <= 1'b0;
                    mb_micro_pkg::FF_SETRCB: o_rr.rcb     <= 1'b1;
                    mb_micro_pkg::FF_CLRJMP: o_rr.jump    <= 1'b0;
                    mb_micro_pkg::FF_SETJMP: o_rr.jump    <= 1'b1;
                    mb_micro_pkg::FF_SETEI:  o_rr.no_intr <= 1'b0;  // Unmask interrupts
                    mb_micro_pkg::FF_CLREI:  o_rr.no_intr <= 1'b1;  // Mask interrupts
                    mb_micro_pkg::FF_CLRTR0: tr0          <= 1'b0;
                    mb_micro_pkg::FF_SETTR0: tr0          <= 1'b1;
                    mb_micro_pkg::FF_CLRTR1: tr1          <= 1'b0;
                    mb_micro_pkg::FF_SETTR1: tr1          <= 1'b1;
                    mb_micro_pkg::FF_CLRTKK: tkk          <= 1'b0;
                    mb_micro_pkg::FF_SETTKK: tkk          <= 1'b1;
                    mb_micro_pkg::FF_SETNR:  emul_mode    <= 1'b0;  // Native mode
                    mb_micro_pkg::FF_SETER:  emul_mode    <= 1'b1;  // Emulation mode
                    mb_micro_pkg::FF_CHTKK:  tkk          <= ~tkk;  // Toggle
                    default: ;
                endcase
            end
            if (i_uinstr.ddev == 3'd3)
                o_rr.cb <= 1'b0;                     // Clear beats SETC
            if (i_uinstr.ise)
                o_rr.rcb <= tkk;                     // Copy beats set/clear
        end
    end

    // --------------------------------------------------
    // Condition multiplexer
    always_comb begin
        case (i_uinstr.cond)
            5'd1:    cond_bit = o_rr.normb;
            5'd2:    cond_bit = o_rr.rndb;
            5'd3:    cond_bit = o_rr.ovrib;
            5'd4:    cond_bit = o_rr.bnb;
            5'd5:    cond_bit = o_rr.ovrftb;
            5'd6:    cond_bit = o_rr.drg;
            5'd7:    cond_bit = emul_mode;
            5'd8:    cond_bit = o_rr.rcb;
            5'd9:    cond_bit = o_rr.cb;
            5'd10:   cond_bit = o_rr.cemlrg;
            5'd12:   cond_bit = tr1;
            5'd13:   cond_bit = o_rr.intstp;
            5'd15:   cond_bit = tkk;
            5'd22:   cond_bit = tr0;
            default: cond_bit = 1'b1;                // Code 0 and missing sources
        endcase
    end

    assign o_ncc = i_uinstr.icc ? cond_bit : ~cond_bit;

    grp_one_hot: assert property (@(posedge clk) disable iff (reset)
        (!i_uinstr.iomp && i_uinstr.ffcnt inside {5'd1, 5'd2, 5'd3})
            |=> $onehot(o_rr.grp));

endmodule

`default_nettype wire

/* mb_sequencer.sv */
`default_nettype none
`timescale 1ns/1ps

module mb_sequencer #(
    parameter int STACK_DEPTH = mb_machine_pkg::STACK_DEPTH_DEF
) (
    input  wire                           clk,
    input  wire                           reset,
    input  wire  mb_micro_pkg::uinstr_t   i_uinstr,  // Current microinstruction
    input  wire  mb_machine_pkg::word_t   i_y,       // Y bus
    input  wire                           i_ncc,     // Condition, active low
    output mb_machine_pkg::uaddr_t        o_uaddr    // Next microaddress
);

    localparam int SPW = $clog2(STACK_DEPTH + 1);
    localparam logic [SPW-1:0] SP_FULL = SPW'(STACK_DEPTH);

    mb_machine_pkg::uaddr_t upc;                     // Microprogram counter
    mb_machine_pkg::uaddr_t stack [STACK_DEPTH];     // Return stack
    logic [SPW-1:0]         sp;                      // Entries in use
    mb_machine_pkg::uaddr_t d_in;                    // Sequencer D input
    mb_machine_pkg::uaddr_t tos;                     // Top of stack
    logic                   pass;                    // Test passed
    logic                   cin;                     // Counter carry-in
    logic                   push;
    logic                   pop;
    logic                   clr;

    // --------------------------------------------------
    // Next address select
    assign d_in = (i_uinstr.map == 2'd3) ? i_y[11:0] : i_uinstr.a;  // Y bus or field a
    assign pass = ~i_ncc;
    assign tos  = (sp == '0) ? '0 : stack[sp - 1'b1];  // Empty stack returns 0
    assign cin  = (i_uinstr.sci ? i_ncc : 1'b1) ^ i_uinstr.ici;

    always_comb begin
        o_uaddr = upc;                               // CONT and dropped codes
        push    = 1'b0;
        pop     = 1'b0;
        clr     = 1'b0;
        case (i_uinstr.sqi)
            mb_micro_pkg::SQ_JZ: begin
                o_uaddr = '0;
                clr     = 1'b1;                      // Empty the stack
            end
            mb_micro_pkg::SQ_CJS: if (pass) begin
                o_uaddr = d_in;
                push    = 1'b1;                      // Save return point
            end
            mb_micro_pkg::SQ_JMAP: o_uaddr = d_in;
            mb_micro_pkg::SQ_CJP: if (pass) o_uaddr = d_in;
            mb_micro_pkg::SQ_CRTN: if (pass) begin
                o_uaddr = tos;
                pop     = (sp != '0);                // No pop when empty
            end
            default: ;
        endcase
    end

    // --------------------------------------------------
    // Counter and stack pointer
    always_ff @(posedge clk) begin
        if (reset) begin
            upc <= '0;
            sp  <= '0;
        end else begin
            upc <= o_uaddr + mb_machine_pkg::uaddr_t'(cin);  // Wraps at 4096
            if (clr)
                sp <= '0;
            else if (push && sp != SP_FULL)
                sp <= sp + 1'b1;                     // Full stack keeps depth
            else if (pop)
                sp <= sp - 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (push)
            stack[(sp == SP_FULL) ? sp - 1'b1 : sp] <= upc;  // Full replaces top
    end

    sp_in_range: assert property (@(posedge clk) disable iff (reset) sp <= SP_FULL);

endmodule

`default_nettype wire

/* mb_micro_pkg.sv */
`default_nettype none

package mb_micro_pkg;

    // Sequencer instruction, Am2910 numbering
    typedef enum logic [3:0] {
        SQ_JZ   = 4'd0,                 // Jump to zero, clear stack
        SQ_CJS  = 4'd1,                 // Conditional jump to subroutine
        SQ_JMAP = 4'd2,                 // Jump to mapped address
        SQ_CJP  = 4'd3,                 // Conditional jump
        SQ_CRTN = 4'd10,                // Conditional return
        SQ_CONT = 4'd14                 // Continue
    } seq_op_e;

    // D bus sources
    typedef enum logic [3:0] {
        DS_NONE  = 4'd0,
        DS_MODGN = 4'd1,                // Group number register
        DS_PROCN = 4'd2,                // Process number register
        DS_RR    = 4'd3                 // Mode register
    } dsrc_e;

    // Y bus destinations
    typedef enum logic [3:0] {
        YD_NONE  = 4'd0,
        YD_MODGN = 4'd1,
        YD_PROCN = 4'd2,
        YD_RR    = 4'd3,
        YD_UREG  = 4'd8                 // Effective address register
    } ydst_e;

    // Flag flip-flop decoder codes
    typedef enum logic [4:0] {
        FF_LOGGRP = 5'd1,  FF_MULGRP = 5'd2,  FF_ADDGRP = 5'd3,
        FF_SETC   = 5'd5,  FF_CLRRCB = 5'd6,  FF_SETRCB = 5'd7,
        FF_CLRJMP = 5'd8,  FF_SETJMP = 5'd9,  FF_SETEI  = 5'd10, FF_CLREI = 5'd11,
        FF_CLRTR0 = 5'd12, FF_SETTR0 = 5'd13, FF_CLRTR1 = 5'd14, FF_SETTR1 = 5'd15,
        FF_CLRTKK = 5'd18, FF_SETTKK = 5'd19, FF_SETNR  = 5'd20,
        FF_SETER  = 5'd22, FF_CHTKK  = 5'd23
    } ffcnt_e;

    // Microinstruction, 56 bits
    typedef struct packed {
        seq_op_e                 sqi;   // Sequencer code
        mb_machine_pkg::uaddr_t  a;     // Branch address
        logic [1:0]              map;   // D input source, 3 is Y bus
        logic                    sci;   // Condition to carry-in
        logic                    ici;   // Carry-in inversion
        logic                    icc;   // Condition polarity
        logic                    ise;   // Interrupt enable, copies tkk to rcb
        logic                    iomp;  // Low selects flag decoder
        logic [4:0]              ffcnt; // Flag set/clear code
        logic [4:0]              cond;  // Condition select
        logic                    csm;   // Modifier memory access
        logic                    wem;   // Modifier memory write
        logic                    mod;   // Privileged access
        logic [1:0]              mnsa;  // Modifier number source
        mb_machine_pkg::modnum_t modnm; // Modifier number from microcode
        dsrc_e                   dsrc;  // D bus source
        ydst_e                   ydst;  // Y bus destination
        logic [2:0]              ddev;  // D device, 3 clears cb
        logic [1:0]              spare; // Reserved
    } uinstr_t;

endpackage

`default_nettype wire

/* mb_machine_pkg.sv */
`default_nettype none

package mb_machine_pkg;

    typedef logic [31:0] word_t;        // Machine word on Y and D buses
    typedef logic [11:0] uaddr_t;       // Microinstruction address
    typedef logic [4:0]  modgn_t;       // Modifier group number
    typedef logic [7:0]  procn_t;       // Process number
    typedef logic [4:0]  modnum_t;      // Modifier number within group

    // Mode register RR, bit 31 first
    typedef struct packed {
        logic [1:0] unused;             // Bits 31..30 not specified
        logic       jump;               // Control transfer flag
        logic       rcb;                // Right command flag
        logic       cb;                 // Address changed by register 16
        logic       no_paging;          // Page mapping disabled
        logic       no_procnm;          // Process number check disabled
        logic       negaddr;            // Negative address mode
        logic       no_rprot;           // Page access protection disabled
        logic       no_wprot;           // Page write protection disabled
        logic       intstp;             // Stop on interrupt
        logic       single_step;        // Single instruction step mode
        logic       cemlrg;             // Reserved emulation bit
        logic       no_wtag;            // Tag check on write disabled
        logic       no_intr;            // External interrupts masked
        logic       no_progtag;         // Program tag handling disabled
        logic       no_badacc;          // Foreign accumulator check disabled
        logic       no_rtag;            // Tag check on operand read disabled
        logic       no_badop;           // Foreign operand check disabled
        logic       drg;                // Dispatcher mode
        logic       ovrftb;             // Stash field overflow check blocked
        logic       bnb;                // Range check blocked
        logic       z;                  // Zero
        logic       n;                  // Negative
        logic       c;                  // Carry
        logic       v;                  // Overflow
        logic       ovrib;              // Overflow interrupt blocked
        logic [2:0] grp;                // Operation group, one-hot
        logic       rndb;               // Rounding blocked
        logic       normb;              // Normalization blocked
    } mode_reg_t;

    localparam int STACK_DEPTH_DEF = 5; // Return stack entries

endpackage

`default_nettype wire
